// ==== serv_pkg.sv ====
package serv_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;
   typedef logic [4:0]  cnt_t;
   typedef logic [6:0]  opcode_t;
   typedef logic [1:0]  rd_src_t;

   // First fetch address
   localparam word_t RESET_PC = 32'h0000_0000;

   // Major opcodes, instr[6:0]
   localparam opcode_t OPC_OP     = 7'b0110011;
   localparam opcode_t OPC_OPIMM  = 7'b0010011;
   localparam opcode_t OPC_LUI    = 7'b0110111;
   localparam opcode_t OPC_LOAD   = 7'b0000011;
   localparam opcode_t OPC_STORE  = 7'b0100011;
   localparam opcode_t OPC_BRANCH = 7'b1100011;
   localparam opcode_t OPC_JAL    = 7'b1101111;

   // Write-back source for rd
   localparam rd_src_t RD_SRC_ALU  = 2'd0;
   localparam rd_src_t RD_SRC_MEM  = 2'd1;
   localparam rd_src_t RD_SRC_CTRL = 2'd2;

   // Last bit position of a serial pass
   localparam cnt_t CNT_LAST = 5'd31;

   typedef enum logic [2:0] {
      ADD,
      SUB,
      AND,
      OR,
      XOR,
      PASS_B
   } alu_sel_t;

   typedef enum logic [2:0] {
      FETCH,
      DECODE,
      INIT,
      MEM,
      RUN
   } phase_t;

endpackage

// ==== serv_wb_if.sv ====
interface serv_wb_if
   import serv_pkg::*;
();

   word_t adr;
   word_t dat;
   logic  we;
   logic  cyc;
   word_t rdt;
   logic  ack;

   modport client (
      output adr, dat, we, cyc,
      input  rdt, ack
   );

   modport bus (
      input  adr, dat, we, cyc,
      output rdt, ack
   );

endinterface

// ==== serv_state.sv ====
module serv_state
   import serv_pkg::*;
(
   input  logic   clk,
   input  logic   i_reset,
   input  logic   i_ibus_ack,
   input  logic   i_dbus_ack,
   input  logic   i_two_phase,
   input  logic   i_mem_op,
   output phase_t o_phase,
   output cnt_t   o_cnt,
   output logic   o_cnt_done
);

   phase_t phase_q;
   phase_t phase_d;
   cnt_t   cnt_q;

   assign o_phase    = phase_q;
   assign o_cnt      = cnt_q;
   assign o_cnt_done = (cnt_q == CNT_LAST);

   always_comb begin
      phase_d = phase_q;
      case (phase_q)
         FETCH: begin
            if (i_ibus_ack) begin
               phase_d = DECODE;
            end
         end
         DECODE: begin
            phase_d = i_two_phase ? INIT : RUN;
         end
         INIT: begin
            // Branches skip the bus and go straight to RUN
            if (o_cnt_done) begin
               phase_d = i_mem_op ? MEM : RUN;
            end
         end
         MEM: begin
            if (i_dbus_ack) begin
               phase_d = RUN;
            end
         end
         RUN: begin
            if (o_cnt_done) begin
               phase_d = FETCH;
            end
         end
         default: begin
            phase_d = FETCH;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         phase_q <= FETCH;
         cnt_q   <= '0;
      end else begin
         phase_q <= phase_d;
         // Wraps to zero after bit 31
         if (phase_q == INIT || phase_q == RUN) begin
            cnt_q <= cnt_q + 5'd1;
         end
      end
   end

endmodule

// ==== serv_decode.sv ====
module serv_decode
   import serv_pkg::*;
(
   input  logic      clk,
   input  word_t     i_ibus_rdt,
   input  logic      i_ibus_ack,
   input  phase_t    i_phase,
   input  cnt_t      i_cnt,
   output logic      o_two_phase,
   output logic      o_mem_op,
   output logic      o_mem_we,
   output alu_sel_t  o_alu_sel,
   output logic      o_use_imm,
   output logic      o_imm,
   output logic      o_rd_en,
   output rd_src_t   o_rd_src,
   output reg_addr_t o_rd_addr,
   output reg_addr_t o_rs1_addr,
   output reg_addr_t o_rs2_addr,
   output logic      o_jump,
   output logic      o_branch_ne
);

   word_t      instr;
   opcode_t    opcode;
   logic [2:0] funct3;
   logic       f3_alu_ok;
   logic       is_op;
   logic       is_opimm;
   logic       is_lui;
   logic       is_load;
   logic       is_store;
   logic       is_branch;
   logic       is_jal;
   word_t      imm_word;

   always_ff @(posedge clk) begin
      if (i_phase == FETCH && i_ibus_ack) begin
         instr <= i_ibus_rdt;
      end
   end

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];

   // Only ADD/SUB, XOR, OR and AND
   assign f3_alu_ok = (funct3 == 3'b000) || (funct3 == 3'b100) ||
                      (funct3 == 3'b110) || (funct3 == 3'b111);

   // Anything outside the subset falls through as a no-op
   assign is_op     = (opcode == OPC_OP) && f3_alu_ok &&
                      ((instr[31:25] == 7'b0000000) ||
                       (instr[31:25] == 7'b0100000 && funct3 == 3'b000));
   assign is_opimm  = (opcode == OPC_OPIMM) && f3_alu_ok;
   assign is_lui    = (opcode == OPC_LUI);
   assign is_load   = (opcode == OPC_LOAD) && (funct3 == 3'b010);
   assign is_store  = (opcode == OPC_STORE) && (funct3 == 3'b010);
   assign is_branch = (opcode == OPC_BRANCH) && (funct3[2:1] == 2'b00);
   assign is_jal    = (opcode == OPC_JAL);

   assign o_two_phase = is_load || is_store || is_branch;
   assign o_mem_op    = is_load || is_store;
   assign o_mem_we    = is_store;
   assign o_use_imm   = is_opimm || is_lui;
   assign o_rd_en     = is_op || is_opimm || is_lui || is_load || is_jal;
   assign o_rd_src    = is_load ? RD_SRC_MEM : (is_jal ? RD_SRC_CTRL : RD_SRC_ALU);
   assign o_rd_addr   = instr[11:7];
   assign o_rs1_addr  = instr[19:15];
   assign o_rs2_addr  = instr[24:20];

   // JAL rides the branch path with branch_ne low, eq stays set without INIT
   assign o_jump      = is_jal || is_branch;
   assign o_branch_ne = is_branch && funct3[0];

   always_comb begin
      if (is_lui) begin
         o_alu_sel = PASS_B;
      end else begin
         case (funct3)
            3'b100:  o_alu_sel = XOR;
            3'b110:  o_alu_sel = OR;
            3'b111:  o_alu_sel = AND;
            default: o_alu_sel = (is_op && instr[30]) ? SUB : ADD;
         endcase
      end
   end

   // Immediate formats, sign bit replicated above the top bit
   always_comb begin
      case (opcode)
         OPC_LUI:    imm_word = {instr[31:12], 12'b0};
         OPC_STORE:  imm_word = {{21{instr[31]}}, instr[30:25], instr[11:7]};
         OPC_BRANCH: imm_word = {{20{instr[31]}}, instr[7], instr[30:25],
                                 instr[11:8], 1'b0};
         OPC_JAL:    imm_word = {{12{instr[31]}}, instr[19:12], instr[20],
                                 instr[30:21], 1'b0};
         default:    imm_word = {{21{instr[31]}}, instr[30:20]};
      endcase
   end

   assign o_imm = imm_word[i_cnt];

endmodule

// ==== serv_alu.sv ====
module serv_alu
   import serv_pkg::*;
(
   input  logic     clk,
   input  logic     i_reset,
   input  phase_t   i_phase,
   input  cnt_t     i_cnt,
   input  logic     i_rs1,
   input  logic     i_rs2,
   input  logic     i_imm,
   input  logic     i_use_imm,
   input  alu_sel_t i_sel,
   output logic     o_rd,
   output logic     o_eq
);

   logic op_b;
   logic b_inv;
   logic carry_q;
   logic carry_in;
   logic sum;

   assign op_b  = i_use_imm ? i_imm : i_rs2;
   assign b_inv = (i_sel == SUB) ? ~op_b : op_b;

   // Bit 0 takes the preset, +1 of two's complement for SUB
   assign carry_in = (i_cnt == '0) ? (i_sel == SUB) : carry_q;
   assign sum      = i_rs1 ^ b_inv ^ carry_in;

   always_comb begin
      case (i_sel)
         AND:     o_rd = i_rs1 & op_b;
         OR:      o_rd = i_rs1 | op_b;
         XOR:     o_rd = i_rs1 ^ op_b;
         PASS_B:  o_rd = op_b;
         default: o_rd = sum;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         carry_q <= 1'b0;
         o_eq    <= 1'b1;
      end else begin
         carry_q <= (i_rs1 & b_inv) | (carry_in & (i_rs1 ^ b_inv));
         if (i_phase == DECODE) begin
            o_eq <= 1'b1;
         end else if (i_phase == INIT && (i_rs1 != op_b)) begin
            o_eq <= 1'b0;
         end
      end
   end

endmodule

// ==== serv_rf.sv ====
module serv_rf
   import serv_pkg::*;
(
   input  logic      clk,
   input  phase_t    i_phase,
   input  cnt_t      i_cnt,
   input  reg_addr_t i_rs1_addr,
   input  reg_addr_t i_rs2_addr,
   input  reg_addr_t i_rd_addr,
   input  logic      i_rd_en,
   input  rd_src_t   i_rd_src,
   input  logic      i_alu_rd,
   input  logic      i_mem_rd,
   input  logic      i_ctrl_rd,
   output logic      o_rs1,
   output logic      o_rs2
);

   word_t regs [32];
   logic  rd_bit;
   logic  wr_en;

   always_comb begin
      case (i_rd_src)
         RD_SRC_MEM:  rd_bit = i_mem_rd;
         RD_SRC_CTRL: rd_bit = i_ctrl_rd;
         default:     rd_bit = i_alu_rd;
      endcase
   end

   // x0 is never written and always reads as zero
   assign wr_en = (i_phase == RUN) && i_rd_en && (i_rd_addr != '0);

   assign o_rs1 = (i_rs1_addr == '0) ? 1'b0 : regs[i_rs1_addr][i_cnt];
   assign o_rs2 = (i_rs2_addr == '0) ? 1'b0 : regs[i_rs2_addr][i_cnt];

   // Bit cnt is read before the edge that overwrites it
   always_ff @(posedge clk) begin
      if (wr_en) begin
         regs[i_rd_addr][i_cnt] <= rd_bit;
      end
   end

endmodule

// ==== serv_ctrl.sv ====
module serv_ctrl
   import serv_pkg::*;
(
   input  logic      clk,
   input  logic      i_reset,
   input  phase_t    i_phase,
   input  cnt_t      i_cnt,
   input  logic      i_imm,
   input  logic      i_jump,
   input  logic      i_branch_ne,
   input  logic      i_eq,
   output logic      o_rd,
   serv_wb_if.client ibus
);

   word_t pc_q;
   logic  cyc_q;
   logic  c4_q;
   logic  cj_q;
   logic  c4_in;
   logic  cj_in;
   logic  four_bit;
   logic  pc4_bit;
   logic  pcj_bit;
   logic  take;
   logic  run_done;

   assign c4_in    = (i_cnt == '0) ? 1'b0 : c4_q;
   assign cj_in    = (i_cnt == '0) ? 1'b0 : cj_q;
   assign four_bit = (i_cnt == 5'd2);
   assign pc4_bit  = pc_q[0] ^ four_bit ^ c4_in;
   assign pcj_bit  = pc_q[0] ^ i_imm ^ cj_in;
   assign take     = i_jump && (i_eq != i_branch_ne);
   assign run_done = (i_phase == RUN) && (i_cnt == CNT_LAST);

   // Link value for JAL
   assign o_rd = pc4_bit;

   assign ibus.adr = pc_q;
   assign ibus.dat = '0;
   assign ibus.we  = 1'b0;
   assign ibus.cyc = cyc_q;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         pc_q  <= RESET_PC;
         cyc_q <= 1'b0;
      end else begin
         // Request goes up together with the move into FETCH
         if (ibus.ack) begin
            cyc_q <= 1'b0;
         end else if (i_phase == FETCH || run_done) begin
            cyc_q <= 1'b1;
         end
         // LSB first, PC is whole again after bit 31
         if (i_phase == RUN) begin
            pc_q <= {take ? pcj_bit : pc4_bit, pc_q[31:1]};
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_phase == RUN) begin
         c4_q <= (pc_q[0] & four_bit) | (c4_in & (pc_q[0] ^ four_bit));
         cj_q <= (pc_q[0] & i_imm) | (cj_in & (pc_q[0] ^ i_imm));
      end
   end

endmodule

// ==== serv_mem_if.sv ====
module serv_mem_if
   import serv_pkg::*;
(
   input  logic      clk,
   input  phase_t    i_phase,
   input  cnt_t      i_cnt,
   input  logic      i_mem_we,
   input  logic      i_rs1,
   input  logic      i_imm,
   input  logic      i_rs2,
   output logic      o_rd,
   serv_wb_if.client dbus
);

   word_t adr_q;
   word_t dat_q;
   logic  carry_q;
   logic  carry_in;
   logic  adr_bit;

   assign carry_in = (i_cnt == '0) ? 1'b0 : carry_q;
   assign adr_bit  = i_rs1 ^ i_imm ^ carry_in;

   always_ff @(posedge clk) begin
      if (i_phase == INIT) begin
         adr_q   <= {adr_bit, adr_q[31:1]};
         dat_q   <= {i_rs2, dat_q[31:1]};
         carry_q <= (i_rs1 & i_imm) | (carry_in & (i_rs1 ^ i_imm));
      end else if (i_phase == MEM) begin
         if (dbus.ack && !i_mem_we) begin
            dat_q <= dbus.rdt;
         end
      end else if (i_phase == RUN) begin
         // Load data goes out to rd one bit per cycle
         dat_q <= {1'b0, dat_q[31:1]};
      end
   end

   assign o_rd = dat_q[0];

   assign dbus.adr = adr_q;
   assign dbus.dat = dat_q;
   assign dbus.cyc = (i_phase == MEM);
   assign dbus.we  = (i_phase == MEM) && i_mem_we;

endmodule

// ==== serv_arbiter.sv ====
module serv_arbiter
   import serv_pkg::*;
(
   input  logic   clk,
   input  logic   i_reset,
   serv_wb_if.bus ibus,
   serv_wb_if.bus dbus,
   output word_t  o_adr,
   output word_t  o_dat,
   output logic   o_we,
   output logic   o_cyc,
   input  word_t  i_rdt,
   input  logic   i_ack
);

   logic busy_q;
   logic gnt_q;
   logic gnt_data;
   logic cyc;

   // Fresh choice only when idle, data wins
   assign gnt_data = busy_q ? gnt_q : dbus.cyc;
   assign cyc      = gnt_data ? dbus.cyc : ibus.cyc;

   assign o_adr = gnt_data ? dbus.adr : ibus.adr;
   assign o_dat = gnt_data ? dbus.dat : ibus.dat;
   assign o_we  = gnt_data ? dbus.we : ibus.we;
   assign o_cyc = cyc;

   assign dbus.ack = i_ack && cyc && gnt_data;
   assign ibus.ack = i_ack && cyc && !gnt_data;
   assign dbus.rdt = gnt_data ? i_rdt : '0;
   assign ibus.rdt = gnt_data ? '0 : i_rdt;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         busy_q <= 1'b0;
         gnt_q  <= 1'b0;
      end else begin
         busy_q <= cyc && !i_ack;
         gnt_q  <= gnt_data;
      end
   end

endmodule

// ==== serv_top.sv ====
module serv_top
   import serv_pkg::*;
(
   input  logic  clk,
   input  logic  i_reset,
   output word_t o_adr,
   output word_t o_dat,
   output logic  o_we,
   output logic  o_cyc,
   input  word_t i_rdt,
   input  logic  i_ack
);

   phase_t    phase;
   cnt_t      cnt;
   logic      two_phase;
   logic      mem_op;
   logic      mem_we;
   alu_sel_t  alu_sel;
   logic      use_imm;
   logic      imm;
   logic      rd_en;
   rd_src_t   rd_src;
   reg_addr_t rd_addr;
   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   logic      jump;
   logic      branch_ne;
   logic      eq;
   logic      rs1;
   logic      rs2;
   logic      alu_rd;
   logic      mem_rd;
   logic      ctrl_rd;

   serv_wb_if ibus ();
   serv_wb_if dbus ();

   serv_state u_state (
      .clk         (clk),
      .i_reset     (i_reset),
      .i_ibus_ack  (ibus.ack),
      .i_dbus_ack  (dbus.ack),
      .i_two_phase (two_phase),
      .i_mem_op    (mem_op),
      .o_phase     (phase),
      .o_cnt       (cnt),
      .o_cnt_done  ()
   );

   serv_decode u_decode (
      .clk         (clk),
      .i_ibus_rdt  (ibus.rdt),
      .i_ibus_ack  (ibus.ack),
      .i_phase     (phase),
      .i_cnt       (cnt),
      .o_two_phase (two_phase),
      .o_mem_op    (mem_op),
      .o_mem_we    (mem_we),
      .o_alu_sel   (alu_sel),
      .o_use_imm   (use_imm),
      .o_imm       (imm),
      .o_rd_en     (rd_en),
      .o_rd_src    (rd_src),
      .o_rd_addr   (rd_addr),
      .o_rs1_addr  (rs1_addr),
      .o_rs2_addr  (rs2_addr),
      .o_jump      (jump),
      .o_branch_ne (branch_ne)
   );

   serv_alu u_alu (
      .clk       (clk),
      .i_reset   (i_reset),
      .i_phase   (phase),
      .i_cnt     (cnt),
      .i_rs1     (rs1),
      .i_rs2     (rs2),
      .i_imm     (imm),
      .i_use_imm (use_imm),
      .i_sel     (alu_sel),
      .o_rd      (alu_rd),
      .o_eq      (eq)
   );

   serv_rf u_rf (
      .clk        (clk),
      .i_phase    (phase),
      .i_cnt      (cnt),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .i_rd_en    (rd_en),
      .i_rd_src   (rd_src),
      .i_alu_rd   (alu_rd),
      .i_mem_rd   (mem_rd),
      .i_ctrl_rd  (ctrl_rd),
      .o_rs1      (rs1),
      .o_rs2      (rs2)
   );

   serv_ctrl u_ctrl (
      .clk         (clk),
      .i_reset     (i_reset),
      .i_phase     (phase),
      .i_cnt       (cnt),
      .i_imm       (imm),
      .i_jump      (jump),
      .i_branch_ne (branch_ne),
      .i_eq        (eq),
      .o_rd        (ctrl_rd),
      .ibus        (ibus.client)
   );

   serv_mem_if u_mem_if (
      .clk      (clk),
      .i_phase  (phase),
      .i_cnt    (cnt),
      .i_mem_we (mem_we),
      .i_rs1    (rs1),
      .i_imm    (imm),
      .i_rs2    (rs2),
      .o_rd     (mem_rd),
      .dbus     (dbus.client)
   );

   serv_arbiter u_arbiter (
      .clk     (clk),
      .i_reset (i_reset),
      .ibus    (ibus.bus),
      .dbus    (dbus.bus),
      .o_adr   (o_adr),
      .o_dat   (o_dat),
      .o_we    (o_we),
      .o_cyc   (o_cyc),
      .i_rdt   (i_rdt),
      .i_ack   (i_ack)
   );

endmodule

// ==== tb_serv.sv ====
module tb_serv
   import serv_pkg::*;
();

   localparam int    CLK_PERIOD  = 10;
   localparam int    RESET_CYC   = 4;
   // Cycles to raise cyc, wait up to 3, ack and decode
   localparam int    FETCH_WORST = 6;
   localparam int    MEM_WORST   = 5;
   localparam word_t DONE_ADR    = 32'h0000_07F0;

   logic  clk;
   logic  i_reset;
   word_t o_adr;
   word_t o_dat;
   logic  o_we;
   logic  o_cyc;
   word_t i_rdt;
   logic  i_ack;

   word_t  mem [256];
   word_t  ref_mem [256];
   word_t  ref_regs [32];
   word_t  ref_pc;
   int     ref_icount;
   bit     ref_ready;
   int     prog_len;
   int     errors;
   integer seed;

   // Bus requests in order, as predicted and as seen at ack
   word_t exp_adr [$];
   logic  exp_we [$];
   word_t exp_dat [$];
   word_t act_adr [$];
   logic  act_we [$];
   word_t act_dat [$];

   logic  req_open;
   word_t req_adr;
   logic  req_we;
   word_t req_dat;
   int    wait_left;

   serv_top u_dut (
      .clk     (clk),
      .i_reset (i_reset),
      .o_adr   (o_adr),
      .o_dat   (o_dat),
      .o_we    (o_we),
      .o_cyc   (o_cyc),
      .i_rdt   (i_rdt),
      .i_ack   (i_ack)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic stop_with_failure();
      $display("Checks failed");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic check_value(string name, word_t actual, word_t expected);
      if (actual !== expected) begin
         errors++;
         $display("[FAIL] %0t %s: got %h, expected %h", $time, name, actual, expected);
         stop_with_failure();
      end
   endtask

   function automatic word_t r_type(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
      return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
   endfunction

   function automatic word_t i_type(logic [6:0] opc, logic [2:0] f3, int rd, int rs1, int imm);
      word_t v;
      v = imm;
      return {v[11:0], 5'(rs1), f3, 5'(rd), opc};
   endfunction

   function automatic word_t s_type(int rs2, int rs1, int imm);
      word_t v;
      v = imm;
      return {v[11:5], 5'(rs2), 5'(rs1), 3'b010, v[4:0], OPC_STORE};
   endfunction

   function automatic word_t b_type(logic [2:0] f3, int rs1, int rs2, int imm);
      word_t v;
      v = imm;
      return {v[12], v[10:5], 5'(rs2), 5'(rs1), f3, v[4:1], v[11], OPC_BRANCH};
   endfunction

   function automatic word_t u_type(int rd, logic [19:0] imm20);
      return {imm20, 5'(rd), OPC_LUI};
   endfunction

   function automatic word_t j_type(int rd, int imm);
      word_t v;
      v = imm;
      return {v[20], v[10:1], v[11], v[19:12], 5'(rd), OPC_JAL};
   endfunction

   function automatic word_t addi(int rd, int rs1, int imm);
      return i_type(OPC_OPIMM, 3'b000, rd, rs1, imm);
   endfunction

   task automatic emit(word_t w);
      mem[prog_len] = w;
      prog_len++;
   endtask

   task automatic load_program();
      emit(addi(1, 0, 'h123));
      emit(addi(2, 0, -86));
      emit(u_type(3, 20'h12345));
      emit(addi(10, 0, 'h200));
      emit(r_type(7'h00, 3'b000, 4, 1, 2));
      emit(r_type(7'h20, 3'b000, 5, 1, 2));
      emit(r_type(7'h00, 3'b111, 6, 3, 2));
      emit(r_type(7'h00, 3'b110, 7, 1, 3));
      emit(r_type(7'h00, 3'b100, 8, 2, 3));
      for (int r = 4; r <= 8; r++) begin
         emit(s_type(r, 10, (r - 4) * 4));
      end
      emit(i_type(OPC_OPIMM, 3'b111, 4, 2, 'h0F0));
      emit(i_type(OPC_OPIMM, 3'b110, 5, 1, -2048));
      emit(i_type(OPC_OPIMM, 3'b100, 6, 3, 'h555));
      // Both results go to x0 and vanish
      emit(addi(0, 1, 7));
      emit(r_type(7'h00, 3'b000, 0, 1, 1));
      emit(s_type(4, 10, 20));
      emit(s_type(5, 10, 24));
      emit(s_type(6, 10, 28));
      emit(s_type(0, 10, 32));
      emit(i_type(OPC_LOAD, 3'b010, 11, 10, 4));
      emit(i_type(OPC_LOAD, 3'b010, 12, 10, 'h40));
      emit(i_type(OPC_LOAD, 3'b010, 13, 10, -4));
      emit(s_type(11, 10, 36));
      emit(s_type(12, 10, 40));
      emit(s_type(13, 10, 44));
      emit(addi(20, 0, 10));
      emit(addi(23, 0, 30));
      emit(addi(26, 0, 0));
      emit(addi(27, 0, 3));
      emit(b_type(3'b000, 1, 1, 8));
      emit(addi(20, 0, 99));
      emit(b_type(3'b001, 1, 1, 8));
      emit(addi(21, 0, 1));
      emit(b_type(3'b000, 1, 2, 8));
      emit(addi(22, 0, 2));
      emit(b_type(3'b001, 1, 2, 8));
      emit(addi(23, 0, 3));
      emit(j_type(24, 12));
      emit(addi(20, 0, 5));
      emit(addi(23, 0, 5));
      // Backward loop, three passes
      emit(addi(26, 26, 1));
      emit(b_type(3'b001, 26, 27, -4));
      emit(j_type(0, 8));
      emit(addi(20, 0, 77));
      // Illegal opcode and SLT, both no-ops here
      emit(32'h0000_0000);
      emit(r_type(7'h00, 3'b010, 20, 1, 2));
      for (int r = 20; r <= 24; r++) begin
         emit(s_type(r, 10, 48 + (r - 20) * 4));
      end
      emit(s_type(26, 10, 68));
      emit(i_type(OPC_LOAD, 3'b010, 29, 10, 68));
      emit(s_type(29, 0, 'h7F0));
   endtask

   function automatic void expect_req(word_t adr, logic we, word_t dat);
      exp_adr.push_back(adr);
      exp_we.push_back(we);
      exp_dat.push_back(dat);
   endfunction

   function automatic word_t alu_result(logic [2:0] f3, word_t a, word_t b);
      case (f3)
         3'b100:  return a ^ b;
         3'b110:  return a | b;
         3'b111:  return a & b;
         default: return a + b;
      endcase
   endfunction

   // Architectural model, runs up to and including the next SW
   function automatic bit ref_next_store(output word_t st_adr, output word_t st_dat);
      word_t      ins;
      word_t      a;
      word_t      b;
      word_t      imm_i;
      word_t      imm_s;
      word_t      imm_b;
      word_t      imm_j;
      word_t      ld_adr;
      word_t      res;
      word_t      next_pc;
      logic [6:0] f7;
      logic [2:0] f3;
      logic       alu_f3;
      logic       wr;
      st_adr = '0;
      st_dat = '0;
      for (int step = 0; step < 4096; step++) begin
         ins = ref_mem[ref_pc[9:2]];
         expect_req(ref_pc, 1'b0, '0);
         ref_icount++;
         f7 = ins[31:25];
         f3 = ins[14:12];
         a = ref_regs[ins[19:15]];
         b = ref_regs[ins[24:20]];
         imm_i = {{20{ins[31]}}, ins[31:20]};
         imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
         imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
         imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
         alu_f3 = (f3 == 3'b000) || (f3 == 3'b100) || (f3 == 3'b110) || (f3 == 3'b111);
         next_pc = ref_pc + 32'd4;
         wr = 1'b0;
         res = '0;
         case (ins[6:0])
            OPC_OP: begin
               if (alu_f3 && (f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'b000))) begin
                  res = (f7 == 7'h20) ? a - b : alu_result(f3, a, b);
                  wr = 1'b1;
               end
            end
            OPC_OPIMM: begin
               if (alu_f3) begin
                  res = alu_result(f3, a, imm_i);
                  wr = 1'b1;
               end
            end
            OPC_LUI: begin
               res = {ins[31:12], 12'b0};
               wr = 1'b1;
            end
            OPC_LOAD: begin
               if (f3 == 3'b010) begin
                  ld_adr = a + imm_i;
                  expect_req(ld_adr, 1'b0, '0);
                  res = ref_mem[ld_adr[9:2]];
                  wr = 1'b1;
               end
            end
            OPC_STORE: begin
               if (f3 == 3'b010) begin
                  st_adr = a + imm_s;
                  st_dat = b;
                  expect_req(st_adr, 1'b1, st_dat);
                  if (st_adr != DONE_ADR) begin
                     ref_mem[st_adr[9:2]] = st_dat;
                  end
                  ref_pc = next_pc;
                  return 1'b1;
               end
            end
            OPC_BRANCH: begin
               if (f3[2:1] == 2'b00 && ((a == b) != f3[0])) begin
                  next_pc = ref_pc + imm_b;
               end
            end
            OPC_JAL: begin
               res = ref_pc + 32'd4;
               wr = 1'b1;
               next_pc = ref_pc + imm_j;
            end
            default: begin
            end
         endcase
         if (wr && ins[11:7] != 5'd0) begin
            ref_regs[ins[11:7]] = res;
         end
         ref_pc = next_pc;
      end
      return 1'b0;
   endfunction

   initial begin
      word_t s_adr;
      word_t s_dat;
      bit    ref_done;
      clk = 1'b0;
      i_reset = 1'b1;
      i_ack = 1'b0;
      i_rdt = '0;
      seed = 44882;
      errors = 0;
      req_open = 1'b0;
      ref_ready = 1'b0;
      ref_done = 1'b0;
      prog_len = 0;
      ref_icount = 0;
      ref_pc = RESET_PC;
      // Unused words hold the inverted byte address
      for (int i = 0; i < 256; i++) begin
         mem[i] = ~(word_t'(i) << 2);
      end
      load_program();
      ref_mem = mem;
      for (int r = 0; r < 32; r++) begin
         ref_regs[r] = '0;
      end
      while (!ref_done) begin
         if (!ref_next_store(s_adr, s_dat)) begin
            $display("Reference model never reached the done store");
            stop_with_failure();
         end else if (s_adr == DONE_ADR) begin
            ref_done = 1'b1;
         end
      end
      ref_ready = 1'b1;
      repeat (RESET_CYC) begin
         @(negedge clk);
         check_value("o_cyc", word_t'(o_cyc), '0);
      end
      i_reset = 1'b0;
      // First fetch goes up in the cycle after release
      @(negedge clk);
      check_value("o_cyc", word_t'(o_cyc), 32'd1);
   end

   // Memory model, answers each request after 0 to 3 wait cycles
   always @(negedge clk) begin
      if (i_ack) begin
         i_ack = 1'b0;
      end else if (o_cyc === 1'b1) begin
         if (!req_open) begin
            req_open = 1'b1;
            req_adr = o_adr;
            req_we = o_we;
            req_dat = o_dat;
            wait_left = $unsigned($random(seed)) % 4;
         end
         check_value("o_adr", o_adr, req_adr);
         check_value("o_we", word_t'(o_we), word_t'(req_we));
         if (req_we) begin
            check_value("o_dat", o_dat, req_dat);
         end
         if (wait_left == 0) begin
            if (req_we) begin
               if (req_adr != DONE_ADR) begin
                  mem[req_adr[9:2]] = req_dat;
               end
            end else begin
               i_rdt = mem[req_adr[9:2]];
            end
            act_adr.push_back(req_adr);
            act_we.push_back(req_we);
            act_dat.push_back(req_dat);
            i_ack = 1'b1;
            req_open = 1'b0;
         end else begin
            wait_left--;
         end
      end else if (req_open) begin
         $display("o_cyc dropped at %0t before the request was acknowledged", $time);
         stop_with_failure();
      end
   end

   // Compares every acknowledged request with the reference sequence
   initial begin
      word_t a;
      logic  we;
      word_t d;
      bit    done_seen;
      done_seen = 1'b0;
      wait (ref_ready);
      while (!done_seen) begin
         wait (act_adr.size() > 0);
         a = act_adr.pop_front();
         we = act_we.pop_front();
         d = act_dat.pop_front();
         if (exp_adr.size() == 0) begin
            $display("DUT made a bus request after the reference sequence ended");
            stop_with_failure();
         end
         check_value("o_adr", a, exp_adr.pop_front());
         check_value("o_we", word_t'(we), word_t'(exp_we.pop_front()));
         if (we) begin
            check_value("o_dat", d, exp_dat.pop_front());
         end else begin
            void'(exp_dat.pop_front());
         end
         done_seen = we && (a == DONE_ADR);
      end
      if (errors == 0) begin
         $display("All checks passed");
         $finish;
      end else begin
         stop_with_failure();
      end
   end

   initial begin
      wait (ref_ready);
      #((ref_icount * (FETCH_WORST + 64 + MEM_WORST) * 2 + RESET_CYC) * CLK_PERIOD);
      $display("Timeout, the done store never arrived");
      stop_with_failure();
   end

endmodule

// ==== verilog.f ====
serv_pkg.sv
serv_wb_if.sv
serv_state.sv
serv_decode.sv
serv_alu.sv
serv_rf.sv
serv_ctrl.sv
serv_mem_if.sv
serv_arbiter.sv
serv_top.sv
tb_serv.sv
